// ==== vfu_settings.svh ====
// VFU sizing macros for lane count, element width and register addressing
`ifndef VFU_SETTINGS_SVH
`define VFU_SETTINGS_SVH

// Lane array
`define VFU_N_LANES 2
`define VFU_ELEN 32

// Vector register file
`define VFU_VREG_COUNT 32
`define VFU_WORDS_PER_VREG 4

// Wide enough for a full register of 8-bit elements
`define VFU_VL_W 6

`endif

// ==== vfu_isa_pkg.sv ====
// Instruction-level types of the VFU: operations, element widths, lane word views
`include "vfu_settings.svh"

package vfu_isa_pkg;

  // One lane-sized scalar
  typedef logic [`VFU_ELEN-1:0] elen_t;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_MINU = 3'd5,
    OP_MAXU = 3'd6
  } vfu_op_e;

  // Same encoding as the vtype SEW field
  typedef enum logic [1:0] {
    SEW_8  = 2'd0,
    SEW_16 = 2'd1,
    SEW_32 = 2'd2
  } vfu_sew_e;

  // One lane word seen as bytes, halfwords or a full word
  typedef union packed {
    logic [`VFU_ELEN/8-1:0][7:0]   b;
    logic [`VFU_ELEN/16-1:0][15:0] h;
    logic [`VFU_ELEN-1:0]          w;
  } lane_word_u;

endpackage

// ==== vfu_pipe_pkg.sv ====
// Pipeline-side types of the VFU: VRF words, byte enables, addresses and the tag
`include "vfu_settings.svh"

package vfu_pipe_pkg;

  localparam int unsigned VrfWordW = `VFU_N_LANES * `VFU_ELEN;
  localparam int unsigned VrfAddrW = $clog2(`VFU_VREG_COUNT * `VFU_WORDS_PER_VREG);

  typedef logic [VrfWordW-1:0]   vrf_word_t;
  typedef logic [VrfWordW/8-1:0] vrf_be_t;
  typedef logic [VrfAddrW-1:0]   vrf_addr_t;

  // Register index and vector length as seen in a request
  typedef logic [$clog2(`VFU_VREG_COUNT)-1:0] vreg_idx_t;
  typedef logic [`VFU_VL_W-1:0]                vfu_vl_t;

  typedef logic [2:0] vfu_id_t;

  // Travels with every word from issue to writeback
  typedef struct packed {
    vrf_addr_t waddr;
    vfu_id_t   id;
    logic      last;
  } vfu_tag_t;

endpackage

// ==== vfu_issue_if.sv ====
// Issue bus carrying one word per cycle from the sequencer to the execute stage
`timescale 1ns/10ps

interface vfu_issue_if
  import vfu_isa_pkg::*;
  import vfu_pipe_pkg::*;
();

  logic      issue_valid;
  vfu_op_e   op;
  vfu_sew_e  sew;

  // First operand is vs1, second is vs2
  vrf_word_t opa;
  vrf_word_t opb;
  elen_t     rs1;
  logic      use_vs1;

  // Elements still to process, including this word
  vfu_vl_t   elems_left;
  vfu_tag_t  tag;

  modport seq (
    output issue_valid, op, sew, opa, opb, rs1, use_vs1, elems_left, tag
  );

  modport lane (
    input issue_valid, op, sew, opa, opb, rs1, use_vs1, tag
  );

  modport wbe (
    input sew, elems_left, tag
  );

endinterface

// ==== vfu_sequencer.sv ====
// VFU sequencer: takes a request, walks the register words and issues one per cycle
`timescale 1ns/10ps
`include "vfu_settings.svh"

module vfu_sequencer
  import vfu_isa_pkg::*;
  import vfu_pipe_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_i,
  // Request
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  vfu_op_e           req_op_i,
  input  vfu_sew_e          req_sew_i,
  input  vfu_vl_t           req_vl_i,
  input  vreg_idx_t         req_vs1_i,
  input  vreg_idx_t         req_vs2_i,
  input  vreg_idx_t         req_vd_i,
  input  elen_t             req_rs1_i,
  input  logic              req_use_vs1_i,
  input  vfu_id_t           req_id_i,
  // VRF read, data comes back in the same cycle
  output vrf_addr_t         vrf_raddr1_o,
  output vrf_addr_t         vrf_raddr2_o,
  input  vrf_word_t         vrf_rdata1_i,
  input  vrf_word_t         vrf_rdata2_i,
  // Issue
  vfu_issue_if.seq          issue
);

  localparam int unsigned WordBytes = `VFU_N_LANES * `VFU_ELEN / 8;
  localparam int unsigned OffW      = $clog2(`VFU_WORDS_PER_VREG);

  function automatic vrf_addr_t word_addr(input vreg_idx_t vreg, input logic [OffW-1:0] off);
    return vrf_addr_t'(vreg) * vrf_addr_t'(`VFU_WORDS_PER_VREG) + vrf_addr_t'(off);
  endfunction

  //////////////////////////////////////////////////
  // Control state

  logic            busy_q;
  vfu_vl_t         left_q;
  logic [OffW-1:0] off_q;

  // Captured request
  vfu_op_e   op_q;
  vfu_sew_e  sew_q;
  vreg_idx_t vs1_q, vs2_q, vd_q;
  elen_t     rs1_q;
  logic      use_vs1_q;
  vfu_id_t   id_q;

  vfu_vl_t epw;
  logic    last_word;
  logic    accept;

  assign req_ready_o = !busy_q;
  assign accept      = req_valid_i && req_ready_o;

  // 8, 4 or 2 elements per VRF word
  assign epw       = vfu_vl_t'(WordBytes) >> sew_q;
  assign last_word = left_q <= epw;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      left_q <= '0;
      off_q  <= '0;
    end else if (accept) begin
      busy_q <= 1'b1;
      left_q <= req_vl_i;
      off_q  <= '0;
    end else if (busy_q) begin
      if (last_word) begin
        busy_q <= 1'b0;
      end else begin
        left_q <= left_q - epw;
        off_q  <= off_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q      <= req_op_i;
      sew_q     <= req_sew_i;
      vs1_q     <= req_vs1_i;
      vs2_q     <= req_vs2_i;
      vd_q      <= req_vd_i;
      rs1_q     <= req_rs1_i;
      use_vs1_q <= req_use_vs1_i;
      id_q      <= req_id_i;
    end
  end

  //////////////////////////////////////////////////
  // Operand read and issue

  assign vrf_raddr1_o = word_addr(vs1_q, off_q);
  assign vrf_raddr2_o = word_addr(vs2_q, off_q);

  assign issue.issue_valid = busy_q;
  assign issue.op          = op_q;
  assign issue.sew         = sew_q;
  assign issue.opa         = vrf_rdata1_i;
  assign issue.opb         = vrf_rdata2_i;
  assign issue.rs1         = rs1_q;
  assign issue.use_vs1     = use_vs1_q;
  assign issue.elems_left  = left_q;
  assign issue.tag         = '{waddr: word_addr(vd_q, off_q), id: id_q, last: last_word};

endmodule

// ==== vfu_lane_array.sv ====
// VFU lane array: element-wise integer operations on every lane, one register stage
`timescale 1ns/10ps
`include "vfu_settings.svh"

module vfu_lane_array
  import vfu_isa_pkg::*;
  import vfu_pipe_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  vfu_issue_if.lane  issue,
  output logic       res_valid_o,
  output vrf_word_t  res_word_o,
  output vfu_tag_t   res_tag_o
);

  localparam int unsigned Elen      = `VFU_ELEN;
  localparam int unsigned ElenB     = Elen / 8;
  localparam int unsigned WordBytes = `VFU_N_LANES * ElenB;

  // Operands arrive zero-extended, so the low bits hold the narrow result
  function automatic elen_t elem_op(input vfu_op_e op, input elen_t a, input elen_t b);
    elen_t res;
    case (op)
      OP_ADD:  res = b + a;
      OP_SUB:  res = b - a;   // vs2 minus vs1 or rs1
      OP_AND:  res = b & a;
      OP_OR:   res = b | a;
      OP_XOR:  res = b ^ a;
      OP_MINU: res = (a < b) ? a : b;
      OP_MAXU: res = (a > b) ? a : b;
      default: res = '0;
    endcase
    return res;
  endfunction

  //////////////////////////////////////////////////
  // Scalar replication

  vrf_word_t opa_word;
  vrf_word_t res_word;

  always_comb begin
    if (issue.use_vs1) begin
      opa_word = issue.opa;
    end else begin
      case (issue.sew)
        SEW_8:   opa_word = {WordBytes{issue.rs1[7:0]}};
        SEW_16:  opa_word = {(WordBytes / 2){issue.rs1[15:0]}};
        default: opa_word = {`VFU_N_LANES{issue.rs1}};
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Lanes

  for (genvar l = 0; l < `VFU_N_LANES; l++) begin : gen_lanes
    lane_word_u a, b, r;

    assign a = opa_word[l*Elen +: Elen];
    assign b = issue.opb[l*Elen +: Elen];

    always_comb begin
      elen_t tmp;
      r = '0;
      case (issue.sew)
        SEW_8: begin
          for (int e = 0; e < ElenB; e++) begin
            tmp = elem_op(issue.op, elen_t'(a.b[e]), elen_t'(b.b[e]));
            r.b[e] = tmp[7:0];
          end
        end
        SEW_16: begin
          for (int e = 0; e < ElenB / 2; e++) begin
            tmp = elem_op(issue.op, elen_t'(a.h[e]), elen_t'(b.h[e]));
            r.h[e] = tmp[15:0];
          end
        end
        default: r.w = elem_op(issue.op, a.w, b.w);
      endcase
    end

    assign res_word[l*Elen +: Elen] = r;
  end

  // Result stage
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= issue.issue_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    res_word_o <= res_word;
    res_tag_o  <= issue.tag;
  end

endmodule

// ==== vfu_wbe_gen.sv ====
// VFU byte-enable generator: write mask of each issued word, aligned with the lanes
`timescale 1ns/10ps
`include "vfu_settings.svh"

module vfu_wbe_gen
  import vfu_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  vfu_issue_if.wbe  issue,
  output vrf_be_t   be_o
);

  // Element count scaled to bytes, up to four bytes per element
  logic [`VFU_VL_W+1:0] nbytes;
  vrf_be_t              be_d;

  assign nbytes = {2'b00, issue.elems_left} << issue.sew;

  // Only the last word is partial, its low bytes are kept
  always_comb begin
    if (issue.tag.last) begin
      be_d = ~(vrf_be_t'('1) << nbytes);
    end else begin
      be_d = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      be_o <= '0;
    end else begin
      be_o <= be_d;
    end
  end

endmodule

// ==== vfu_writeback.sv ====
// VFU writeback: drives the VRF write port and the completion pulse
`timescale 1ns/10ps

module vfu_writeback
  import vfu_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // From the lane array and the byte-enable generator
  input  logic      res_valid_i,
  input  vrf_word_t res_word_i,
  input  vfu_tag_t  res_tag_i,
  input  vrf_be_t   be_i,
  // VRF write
  output vrf_addr_t vrf_waddr_o,
  output vrf_word_t vrf_wdata_o,
  output logic      vrf_we_o,
  output vrf_be_t   vrf_wbe_o,
  // Response
  output logic      rsp_valid_o,
  output vfu_id_t   rsp_id_o
);

  vfu_tag_t tag_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vrf_we_o <= 1'b0;
    end else begin
      vrf_we_o <= res_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q       <= res_tag_i;
    vrf_wdata_o <= res_word_i;
    vrf_wbe_o   <= be_i;
  end

  assign vrf_waddr_o = tag_q.waddr;

  // Completion goes out with the write of the last word
  assign rsp_valid_o = vrf_we_o && tag_q.last;
  assign rsp_id_o    = tag_q.id;

endmodule

// ==== vfu_top.sv ====
// Integer vector functional unit top: sequencer, lane array, mask and writeback
`timescale 1ns/10ps

module vfu_top
  import vfu_isa_pkg::*;
  import vfu_pipe_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // Request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vfu_op_e   req_op_i,
  input  vfu_sew_e  req_sew_i,
  input  vfu_vl_t   req_vl_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  vreg_idx_t req_vd_i,
  input  elen_t     req_rs1_i,
  input  logic      req_use_vs1_i,
  input  vfu_id_t   req_id_i,
  // VRF read
  output vrf_addr_t vrf_raddr1_o,
  output vrf_addr_t vrf_raddr2_o,
  input  vrf_word_t vrf_rdata1_i,
  input  vrf_word_t vrf_rdata2_i,
  // VRF write
  output vrf_addr_t vrf_waddr_o,
  output vrf_word_t vrf_wdata_o,
  output logic      vrf_we_o,
  output vrf_be_t   vrf_wbe_o,
  // Response
  output logic      rsp_valid_o,
  output vfu_id_t   rsp_id_o
);

  vfu_issue_if issue_bus ();

  logic      res_valid;
  vrf_word_t res_word;
  vfu_tag_t  res_tag;
  vrf_be_t   res_be;

  //////////////////////////////////////////////////
  // Issue

  vfu_sequencer u_sequencer (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_sew_i     (req_sew_i),
    .req_vl_i      (req_vl_i),
    .req_vs1_i     (req_vs1_i),
    .req_vs2_i     (req_vs2_i),
    .req_vd_i      (req_vd_i),
    .req_rs1_i     (req_rs1_i),
    .req_use_vs1_i (req_use_vs1_i),
    .req_id_i      (req_id_i),
    .vrf_raddr1_o  (vrf_raddr1_o),
    .vrf_raddr2_o  (vrf_raddr2_o),
    .vrf_rdata1_i  (vrf_rdata1_i),
    .vrf_rdata2_i  (vrf_rdata2_i),
    .issue         (issue_bus)
  );

  //////////////////////////////////////////////////
  // Execute, results and masks side by side

  vfu_lane_array u_lane_array (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .issue       (issue_bus),
    .res_valid_o (res_valid),
    .res_word_o  (res_word),
    .res_tag_o   (res_tag)
  );

  vfu_wbe_gen u_wbe_gen (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .issue (issue_bus),
    .be_o  (res_be)
  );

  vfu_writeback u_writeback (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .res_valid_i (res_valid),
    .res_word_i  (res_word),
    .res_tag_i   (res_tag),
    .be_i        (res_be),
    .vrf_waddr_o (vrf_waddr_o),
    .vrf_wdata_o (vrf_wdata_o),
    .vrf_we_o    (vrf_we_o),
    .vrf_wbe_o   (vrf_wbe_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_id_o    (rsp_id_o)
  );

endmodule

// ==== vfu_tb_ref.svh ====
// VFU testbench reference model and random number generator
`ifndef VFU_TB_REF_SVH
`define VFU_TB_REF_SVH

// One step of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x;
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// Expected vd image after one request
// Elements at or beyond vl keep the old vd bytes
function automatic vreg_img_t ref_vreg(
  input vfu_op_e   op,
  input vfu_sew_e  sew,
  input int        vl,
  input logic      use_vs1,
  input logic [31:0] rs1,
  input vreg_img_t src1,
  input vreg_img_t src2,
  input vreg_img_t vd_old
);
  vreg_img_t   res;
  logic [31:0] mask;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  int          w;
  res  = vd_old;
  w    = 8 << sew;
  mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
  for (int i = 0; i < vl; i++) begin
    // Scalar operand is the low element of rs1
    a = use_vs1 ? (32'(src1 >> (i * w)) & mask) : (rs1 & mask);
    b = 32'(src2 >> (i * w)) & mask;
    case (op)
      OP_ADD:  r = b + a;
      OP_SUB:  r = b - a;
      OP_AND:  r = b & a;
      OP_OR:   r = b | a;
      OP_XOR:  r = b ^ a;
      OP_MINU: r = (a < b) ? a : b;
      OP_MAXU: r = (a > b) ? a : b;
      default: r = 32'd0;
    endcase
    r   = r & mask;
    res = (res & ~(vreg_img_t'(mask) << (i * w))) | (vreg_img_t'(r) << (i * w));
  end
  return res;
endfunction

`endif

// ==== vfu_tb.sv ====
// Testbench for the VFU with a VRF model, request stimulus and reference checks
`timescale 1ns/10ps
`include "vfu_settings.svh"

module vfu_tb
  import vfu_isa_pkg::*;
  import vfu_pipe_pkg::*;
();

  localparam int unsigned wpr         = `VFU_WORDS_PER_VREG;
  localparam int unsigned vrf_words   = `VFU_VREG_COUNT * `VFU_WORDS_PER_VREG;
  localparam int unsigned reg_bits    = wpr * VrfWordW;
  localparam int unsigned n_req       = 54;
  localparam int unsigned cycle_limit = 40 * n_req + 200;

  typedef logic [reg_bits-1:0] vreg_img_t;

  `include "vfu_tb_ref.svh"

  logic      clk, rst;
  logic      req_valid, req_ready, req_use_vs1;
  vfu_op_e   req_op;
  vfu_sew_e  req_sew;
  vfu_vl_t   req_vl;
  vreg_idx_t req_vs1, req_vs2, req_vd;
  elen_t     req_rs1;
  vfu_id_t   req_id, rsp_id;
  vrf_addr_t vrf_raddr1, vrf_raddr2, vrf_waddr;
  vrf_word_t vrf_rdata1, vrf_rdata2, vrf_wdata;
  vrf_be_t   vrf_wbe;
  logic      vrf_we, rsp_valid;

  vrf_word_t   vrf_mem [vrf_words];
  vrf_word_t   exp_mem [vrf_words];
  logic [31:0] rng;
  vfu_id_t     next_id;
  int          data_errs, rsp_errs, hs_errs;
  int unsigned cycles;

  // Outstanding requests in issue order
  vfu_id_t   exp_id_q [$];
  vreg_idx_t exp_vd_q [$];
  vreg_img_t exp_img_q [$];
  string     name_q [$];

  // Taken requests waiting for their ready-low period to end
  int        low_words_q [$];
  string     low_name_q [$];
  int        low_cycles;
  int        low_words;
  string     low_name;

  vfu_top uut (
    .clk_i (clk), .rst_i (rst),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_op_i (req_op),
    .req_sew_i (req_sew), .req_vl_i (req_vl), .req_vs1_i (req_vs1),
    .req_vs2_i (req_vs2), .req_vd_i (req_vd), .req_rs1_i (req_rs1),
    .req_use_vs1_i (req_use_vs1), .req_id_i (req_id),
    .vrf_raddr1_o (vrf_raddr1), .vrf_raddr2_o (vrf_raddr2),
    .vrf_rdata1_i (vrf_rdata1), .vrf_rdata2_i (vrf_rdata2),
    .vrf_waddr_o (vrf_waddr), .vrf_wdata_o (vrf_wdata), .vrf_we_o (vrf_we),
    .vrf_wbe_o (vrf_wbe), .rsp_valid_o (rsp_valid), .rsp_id_o (rsp_id)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////
  // VRF model with combinational read and byte-masked write

  assign vrf_rdata1 = vrf_mem[vrf_raddr1];
  assign vrf_rdata2 = vrf_mem[vrf_raddr2];

  always @(posedge clk) begin
    if (vrf_we) begin
      for (int k = 0; k < VrfWordW / 8; k++) begin
        if (vrf_wbe[k]) begin
          vrf_mem[vrf_waddr][k*8 +: 8] <= vrf_wdata[k*8 +: 8];
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic vreg_img_t vrf_image(input vreg_idx_t idx);
    vreg_img_t img;
    for (int w = 0; w < wpr; w++) begin
      img[w*VrfWordW +: VrfWordW] = vrf_mem[idx * wpr + w];
    end
    return img;
  endfunction

  function automatic vreg_img_t exp_image(input vreg_idx_t idx);
    vreg_img_t img;
    for (int w = 0; w < wpr; w++) begin
      img[w*VrfWordW +: VrfWordW] = exp_mem[idx * wpr + w];
    end
    return img;
  endfunction

  // Sources come from v0..v15 and results go to v16..v31 so overlapping requests never chain
  task automatic send_req(input string name, input vfu_op_e op, input vfu_sew_e sew,
                          input int vl, input logic use_vs1);
    vreg_idx_t   vs1, vs2, vd;
    logic [31:0] rs1;
    vreg_img_t   img;
    int          epw;
    vs1   = vreg_idx_t'(next_rand() % 16);
    vs2   = vreg_idx_t'(next_rand() % 16);
    vd    = vreg_idx_t'(16 + next_rand() % 16);
    rs1   = next_rand();
    img   = ref_vreg(op, sew, vl, use_vs1, rs1, exp_image(vs1), exp_image(vs2), exp_image(vd));
    for (int w = 0; w < wpr; w++) begin
      exp_mem[vd * wpr + w] = img[w*VrfWordW +: VrfWordW];
    end
    exp_id_q.push_back(next_id);
    exp_vd_q.push_back(vd);
    exp_img_q.push_back(img);
    name_q.push_back(name);
    epw   = 8 >> sew;
    req_valid   = 1'b1;
    req_op      = op;
    req_sew     = sew;
    req_vl      = vfu_vl_t'(vl);
    req_vs1     = vs1;
    req_vs2     = vs2;
    req_vd      = vd;
    req_rs1     = rs1;
    req_use_vs1 = use_vs1;
    req_id      = next_id;
    next_id     = next_id + 3'd1;
    // Held while the previous request still keeps ready low
    while (!req_ready) begin
      @(negedge clk);
    end
    // Taken at the rising edge in between
    @(negedge clk);
    req_valid = 1'b0;
    low_words_q.push_back((vl + epw - 1) / epw);
    low_name_q.push_back(name);
  endtask

  //////////////////////////////////////////////////
  // Ready-low length against the words of the request taken

  always @(negedge clk) begin
    if (!req_ready) begin
      low_cycles = low_cycles + 1;
    end else if (low_cycles != 0) begin
      assert (low_words_q.size() != 0) else begin
        $display("Ready went low with no request taken");
        hs_errs++;
      end
      if (low_words_q.size() != 0) begin
        low_words = low_words_q.pop_front();
        low_name  = low_name_q.pop_front();
        assert (low_cycles == low_words) else begin
          $display("CHECK FAILED %s ready low cycles: expected %0d, actual %0d",
                   low_name, low_words, low_cycles);
          hs_errs++;
        end
      end
      low_cycles = 0;
    end
  end

  //////////////////////////////////////////////////
  // Response and data compare

  logic      chk_pending;
  vreg_idx_t chk_vd;
  vreg_img_t chk_img;
  string     chk_name;
  vfu_id_t   chk_id;

  always @(negedge clk) begin
    // Last word was written at the rising edge after the response
    if (chk_pending) begin
      assert (vrf_image(chk_vd) == chk_img) else begin
        $display("CHECK FAILED %s vd data: expected %h, actual %h",
                 chk_name, chk_img, vrf_image(chk_vd));
        data_errs++;
      end
      chk_pending = 1'b0;
    end
    if (rsp_valid) begin
      assert (exp_id_q.size() != 0) else begin
        $display("Response with ID %0d arrived with no request outstanding", rsp_id);
        rsp_errs++;
      end
      if (exp_id_q.size() != 0) begin
        chk_id      = exp_id_q.pop_front();
        chk_vd      = exp_vd_q.pop_front();
        chk_img     = exp_img_q.pop_front();
        chk_name    = name_q.pop_front();
        chk_pending = 1'b1;
        assert (rsp_id == chk_id) else begin
          $display("CHECK FAILED %s response ID: expected %0d, actual %0d",
                   chk_name, chk_id, rsp_id);
          rsp_errs++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus

  initial begin
    int        s, vl, epw, elems;
    vrf_word_t init_word;
    clk         = 1'b0;
    rst         = 1'b1;
    req_valid   = 1'b0;
    req_op      = OP_ADD;
    req_sew     = SEW_8;
    req_vl      = '0;
    req_vs1     = '0;
    req_vs2     = '0;
    req_vd      = '0;
    req_rs1     = '0;
    req_use_vs1 = 1'b0;
    req_id      = '0;
    rng         = 32'd80695;
    next_id     = '0;
    cycles      = 0;
    chk_pending = 1'b0;
    low_cycles  = 0;
    data_errs   = 0;
    rsp_errs    = 0;
    hs_errs     = 0;
    for (int a = 0; a < vrf_words; a++) begin
      init_word  = {next_rand(), next_rand()};
      vrf_mem[a] <= init_word;
      exp_mem[a] = init_word;
    end
    repeat (5) @(negedge clk);
    rst = 1'b0;
    // Idle outputs after reset
    repeat (3) begin
      @(negedge clk);
      assert (req_ready && !vrf_we && !rsp_valid) else begin
        $display("Outputs not idle after reset: ready %b, we %b, rsp %b",
                 req_ready, vrf_we, rsp_valid);
        hs_errs++;
      end
    end
    // Full registers with vector-vector then vector-scalar operands and random gaps
    for (int u = 1; u >= 0; u--) begin
      for (s = 0; s < 3; s++) begin
        for (int o = 0; o < 7; o++) begin
          repeat (next_rand() % 3) @(negedge clk);
          send_req($sformatf("%s op%0d sew%0d", u ? "vv_full" : "vx_full", o, s),
                   vfu_op_e'(o), vfu_sew_e'(s), 32 >> s, u[0]);
        end
      end
    end
    // Partial vl that never fills the last word
    for (int n = 0; n < 12; n++) begin
      s     = int'(next_rand() % 3);
      epw   = 8 >> s;
      elems = 32 >> s;
      vl    = 1 + int'(next_rand() % (elems - 1));
      if (vl % epw == 0) begin
        vl = vl - 1;
      end
      repeat (next_rand() % 3) @(negedge clk);
      send_req($sformatf("partial %0d vl%0d sew%0d", n, vl, s),
               vfu_op_e'(next_rand() % 7), vfu_sew_e'(s), vl, next_rand() % 2 == 0);
    end
    while (exp_id_q.size() != 0 || chk_pending) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    assert (low_words_q.size() == 0) else begin
      $display("A taken request never pulled ready low");
      hs_errs++;
    end
    $display("Errors: data %0d, response %0d, handshake %0d", data_errs, rsp_errs, hs_errs);
    if (data_errs + rsp_errs + hs_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== vfu_top.f ====
+incdir+.
vfu_isa_pkg.sv
vfu_pipe_pkg.sv
vfu_issue_if.sv
vfu_sequencer.sv
vfu_lane_array.sv
vfu_wbe_gen.sv
vfu_writeback.sv
vfu_top.sv
vfu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := vfu_tb
RTL_TOP    := vfu_top
FILELIST   := vfu_top.f
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)
SOURCES    := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST PASSED$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
